// ==== corePkg.sv ====
package corePkg;

    // Datapath and register index widths.
    localparam int xlen = 32;
    localparam int regAddrBits = 5;

    localparam logic [xlen-1:0] resetPc = '0;

    // ALU operations.
    localparam logic [3:0] aluAdd = 4'd0;
    localparam logic [3:0] aluSub = 4'd1;
    localparam logic [3:0] aluAnd = 4'd2;
    localparam logic [3:0] aluOr = 4'd3;
    localparam logic [3:0] aluXor = 4'd4;
    localparam logic [3:0] aluSlt = 4'd5;
    localparam logic [3:0] aluPassB = 4'd6;

    // Writeback value select.
    localparam logic [1:0] resAlu = 2'd0;
    localparam logic [1:0] resPcPlus4 = 2'd1;

    // RV32I major opcodes.
    localparam logic [6:0] opOp = 7'b0110011;
    localparam logic [6:0] opOpImm = 7'b0010011;
    localparam logic [6:0] opLui = 7'b0110111;
    localparam logic [6:0] opAuipc = 7'b0010111;
    localparam logic [6:0] opJal = 7'b1101111;
    localparam logic [6:0] opJalr = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;

    // Branch conditions in funct3.
    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;
    localparam logic [2:0] f3Blt = 3'b100;
    localparam logic [2:0] f3Bge = 3'b101;

endpackage

// ==== fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     redirect,
    input  logic [corePkg::xlen-1:0] redirectPc,
    output logic                     wbCyc,
    output logic                     wbStb,
    output logic [corePkg::xlen-1:0] wbAdr,
    input  logic [corePkg::xlen-1:0] wbDatI,
    input  logic                     wbAck,
    output logic                     fdValid,
    output logic [corePkg::xlen-1:0] fdInstr,
    output logic [corePkg::xlen-1:0] fdPc
);
    import corePkg::*;

    logic            reqActive;
    logic            discard;
    logic            ackSeen;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] targetPc;

    // The request stays up after an ack, so the next beat starts at once.
    assign wbCyc = reqActive;
    assign wbStb = reqActive;
    assign wbAdr = pc;
    assign ackSeen = reqActive && wbAck;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            reqActive <= 1'b0;
            discard <= 1'b0;
            fdValid <= 1'b0;
            pc <= resetPc;
        end else begin
            reqActive <= 1'b1;
            fdValid <= ackSeen && !redirect && !discard;
            // A redirect mid-transfer waits for the ack before moving the address.
            if (redirect && !ackSeen) begin
                discard <= 1'b1;
            end else if (ackSeen) begin
                discard <= 1'b0;
            end
            if (ackSeen) begin
                if (redirect) begin
                    pc <= redirectPc;
                end else if (discard) begin
                    pc <= targetPc;
                end else begin
                    pc <= pc + xlen'(4);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (redirect && !ackSeen) begin
            targetPc <= redirectPc;
        end
        if (ackSeen) begin
            fdInstr <= wbDatI;
            fdPc <= pc;
        end
    end

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic [corePkg::regAddrBits-1:0] rs1Addr,
    input  logic [corePkg::regAddrBits-1:0] rs2Addr,
    output logic [corePkg::xlen-1:0]        rs1Data,
    output logic [corePkg::xlen-1:0]        rs2Data,
    input  logic                            we,
    input  logic [corePkg::regAddrBits-1:0] waddr,
    input  logic [corePkg::xlen-1:0]        wdata
);
    import corePkg::*;

    // x0 has no storage.
    logic [xlen-1:0] regs [1:2**regAddrBits-1];

    // Same-cycle writes bypass to the reader.
    function automatic logic [xlen-1:0] readPort(input logic [regAddrBits-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (we && addr == waddr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1Data = readPort(rs1Addr);
        rs2Data = readPort(rs2Addr);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 2**regAddrBits; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            fdValid,
    input  logic [corePkg::xlen-1:0]        fdInstr,
    input  logic [corePkg::xlen-1:0]        fdPc,
    input  logic                            rfWe,
    input  logic [corePkg::regAddrBits-1:0] rfWaddr,
    input  logic [corePkg::xlen-1:0]        rfWdata,
    output logic                            validD,
    output logic                            regWriteD,
    output logic [1:0]                      resultSrcD,
    output logic                            jumpD,
    output logic                            jumpRegD,
    output logic                            branchD,
    output logic [3:0]                      aluControlD,
    output logic                            aluSrcImmD,
    output logic                            aluSrcPcD,
    output logic [corePkg::xlen-1:0]        rs1DataD,
    output logic [corePkg::xlen-1:0]        rs2DataD,
    output logic [corePkg::xlen-1:0]        pcD,
    output logic [corePkg::xlen-1:0]        pcPlus4D,
    output logic [corePkg::xlen-1:0]        immD,
    output logic [corePkg::regAddrBits-1:0] rdD,
    output logic [2:0]                      funct3D
);
    import corePkg::*;

    logic [6:0]      opcode;
    logic [6:0]      funct7;
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immU;
    logic [xlen-1:0] immB;
    logic [xlen-1:0] immJ;
    logic            known;
    logic            regWrite;

    assign opcode = fdInstr[6:0];
    assign funct7 = fdInstr[31:25];
    assign rdD = fdInstr[11:7];
    assign funct3D = fdInstr[14:12];
    assign pcD = fdPc;
    assign pcPlus4D = fdPc + xlen'(4);

    assign immI = {{20{fdInstr[31]}}, fdInstr[31:20]};
    assign immU = {fdInstr[31:12], 12'b0};
    assign immB = {{19{fdInstr[31]}}, fdInstr[31], fdInstr[7], fdInstr[30:25],
                   fdInstr[11:8], 1'b0};
    assign immJ = {{11{fdInstr[31]}}, fdInstr[31], fdInstr[19:12], fdInstr[20],
                   fdInstr[30:21], 1'b0};

    regFile rf0 (
        .clk(clk),
        .rstN(rstN),
        .rs1Addr(fdInstr[19:15]),
        .rs2Addr(fdInstr[24:20]),
        .rs1Data(rs1DataD),
        .rs2Data(rs2DataD),
        .we(rfWe),
        .waddr(rfWaddr),
        .wdata(rfWdata)
    );

    always_comb begin
        known = 1'b1;
        regWrite = 1'b1;
        resultSrcD = resAlu;
        jumpD = 1'b0;
        jumpRegD = 1'b0;
        branchD = 1'b0;
        aluControlD = aluAdd;
        aluSrcImmD = 1'b0;
        aluSrcPcD = 1'b0;
        immD = immI;
        case (opcode)
            opOp, opOpImm: begin
                aluSrcImmD = (opcode == opOpImm);
                case (funct3D)
                    3'b000: aluControlD = (opcode == opOp && funct7[5]) ? aluSub : aluAdd;
                    3'b010: aluControlD = aluSlt;
                    3'b100: aluControlD = aluXor;
                    3'b110: aluControlD = aluOr;
                    3'b111: aluControlD = aluAnd;
                    default: known = 1'b0;
                endcase
            end
            opLui, opAuipc: begin
                // AUIPC adds the upper immediate to the PC.
                aluSrcImmD = 1'b1;
                aluSrcPcD = (opcode == opAuipc);
                aluControlD = (opcode == opLui) ? aluPassB : aluAdd;
                immD = immU;
            end
            opJal, opJalr: begin
                jumpD = 1'b1;
                jumpRegD = (opcode == opJalr);
                resultSrcD = resPcPlus4;
                immD = (opcode == opJal) ? immJ : immI;
            end
            opBranch: begin
                regWrite = 1'b0;
                branchD = 1'b1;
                immD = immB;
                known = (funct3D == f3Beq) || (funct3D == f3Bne) ||
                        (funct3D == f3Blt) || (funct3D == f3Bge);
            end
            default: begin
                known = 1'b0;
            end
        endcase
    end

    assign validD = fdValid && known;
    assign regWriteD = validD && regWrite;

endmodule

// ==== idExReg.sv ====
`timescale 1ns/1ps

module idExReg (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            flush,
    input  logic                            validD,
    input  logic                            regWriteD,
    input  logic [1:0]                      resultSrcD,
    input  logic                            jumpD,
    input  logic                            jumpRegD,
    input  logic                            branchD,
    input  logic [3:0]                      aluControlD,
    input  logic                            aluSrcImmD,
    input  logic                            aluSrcPcD,
    input  logic [corePkg::xlen-1:0]        rs1DataD,
    input  logic [corePkg::xlen-1:0]        rs2DataD,
    input  logic [corePkg::xlen-1:0]        pcD,
    input  logic [corePkg::xlen-1:0]        pcPlus4D,
    input  logic [corePkg::xlen-1:0]        immD,
    input  logic [corePkg::regAddrBits-1:0] rdD,
    input  logic [2:0]                      funct3D,
    output logic                            validE,
    output logic                            regWriteE,
    output logic [1:0]                      resultSrcE,
    output logic                            jumpE,
    output logic                            jumpRegE,
    output logic                            branchE,
    output logic [3:0]                      aluControlE,
    output logic                            aluSrcImmE,
    output logic                            aluSrcPcE,
    output logic [corePkg::xlen-1:0]        rs1DataE,
    output logic [corePkg::xlen-1:0]        rs2DataE,
    output logic [corePkg::xlen-1:0]        pcE,
    output logic [corePkg::xlen-1:0]        pcPlus4E,
    output logic [corePkg::xlen-1:0]        immE,
    output logic [corePkg::regAddrBits-1:0] rdE,
    output logic [2:0]                      funct3E
);

    // A flush turns the stage into a bubble.
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            {validE, regWriteE, resultSrcE, jumpE, jumpRegE, branchE, aluControlE,
             aluSrcImmE, aluSrcPcE, rs1DataE, rs2DataE, pcE, pcPlus4E, immE, rdE,
             funct3E} <= '0;
        end else begin
            validE <= validD;
            regWriteE <= regWriteD;
            resultSrcE <= resultSrcD;
            jumpE <= jumpD;
            jumpRegE <= jumpRegD;
            branchE <= branchD;
            aluControlE <= aluControlD;
            aluSrcImmE <= aluSrcImmD;
            aluSrcPcE <= aluSrcPcD;
            rs1DataE <= rs1DataD;
            rs2DataE <= rs2DataD;
            pcE <= pcD;
            pcPlus4E <= pcPlus4D;
            immE <= immD;
            rdE <= rdD;
            funct3E <= funct3D;
        end
    end

endmodule

// ==== executeStage.sv ====
`timescale 1ns/1ps

module executeStage (
    input  logic                            validE,
    input  logic                            regWriteE,
    input  logic [1:0]                      resultSrcE,
    input  logic                            jumpE,
    input  logic                            jumpRegE,
    input  logic                            branchE,
    input  logic [3:0]                      aluControlE,
    input  logic                            aluSrcImmE,
    input  logic                            aluSrcPcE,
    input  logic [corePkg::xlen-1:0]        rs1DataE,
    input  logic [corePkg::xlen-1:0]        rs2DataE,
    input  logic [corePkg::xlen-1:0]        pcE,
    input  logic [corePkg::xlen-1:0]        pcPlus4E,
    input  logic [corePkg::xlen-1:0]        immE,
    input  logic [corePkg::regAddrBits-1:0] rdE,
    input  logic [2:0]                      funct3E,
    output logic                            rfWe,
    output logic [corePkg::regAddrBits-1:0] rfWaddr,
    output logic [corePkg::xlen-1:0]        rfWdata,
    output logic                            redirect,
    output logic [corePkg::xlen-1:0]        redirectPc,
    output logic                            retireValid,
    output logic [corePkg::xlen-1:0]        retirePc,
    output logic [corePkg::regAddrBits-1:0] retireRd,
    output logic [corePkg::xlen-1:0]        retireData
);
    import corePkg::*;

    logic [xlen-1:0] srcA;
    logic [xlen-1:0] srcB;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] wbValue;
    logic            branchTaken;

    assign srcA = aluSrcPcE ? pcE : rs1DataE;
    assign srcB = aluSrcImmE ? immE : rs2DataE;

    always_comb begin
        case (aluControlE)
            aluSub: aluResult = srcA - srcB;
            aluAnd: aluResult = srcA & srcB;
            aluOr: aluResult = srcA | srcB;
            aluXor: aluResult = srcA ^ srcB;
            aluSlt: aluResult = xlen'($signed(srcA) < $signed(srcB));
            aluPassB: aluResult = srcB;
            default: aluResult = srcA + srcB;
        endcase
    end

    // Branches compare the register operands directly.
    always_comb begin
        case (funct3E)
            f3Beq: branchTaken = (rs1DataE == rs2DataE);
            f3Bne: branchTaken = (rs1DataE != rs2DataE);
            f3Blt: branchTaken = ($signed(rs1DataE) < $signed(rs2DataE));
            f3Bge: branchTaken = ($signed(rs1DataE) >= $signed(rs2DataE));
            default: branchTaken = 1'b0;
        endcase
    end

    assign redirect = validE && (jumpE || (branchE && branchTaken));
    assign redirectPc = jumpRegE ? ((rs1DataE + immE) & ~xlen'(1)) : (pcE + immE);

    assign wbValue = (resultSrcE == resPcPlus4) ? pcPlus4E : aluResult;

    // Writes to x0 are dropped here.
    assign rfWe = validE && regWriteE && (rdE != '0);
    assign rfWaddr = rdE;
    assign rfWdata = wbValue;

    assign retireValid = validE;
    assign retirePc = pcE;
    assign retireRd = rfWe ? rdE : '0;
    assign retireData = rfWe ? wbValue : '0;

endmodule

// ==== coreTop.sv ====
`timescale 1ns/1ps

module coreTop (
    input  logic                            clk,
    input  logic                            rstN,
    output logic                            wbCyc,
    output logic                            wbStb,
    output logic [corePkg::xlen-1:0]        wbAdr,
    input  logic [corePkg::xlen-1:0]        wbDatI,
    input  logic                            wbAck,
    output logic                            retireValid,
    output logic [corePkg::xlen-1:0]        retirePc,
    output logic [corePkg::regAddrBits-1:0] retireRd,
    output logic [corePkg::xlen-1:0]        retireData
);
    import corePkg::*;

    logic                   fdValid;
    logic [xlen-1:0]        fdInstr;
    logic [xlen-1:0]        fdPc;
    logic                   redirect;
    logic [xlen-1:0]        redirectPc;
    logic                   rfWe;
    logic [regAddrBits-1:0] rfWaddr;
    logic [xlen-1:0]        rfWdata;

    // Decoded bundle.
    logic                   validD;
    logic                   regWriteD;
    logic [1:0]             resultSrcD;
    logic                   jumpD;
    logic                   jumpRegD;
    logic                   branchD;
    logic [3:0]             aluControlD;
    logic                   aluSrcImmD;
    logic                   aluSrcPcD;
    logic [xlen-1:0]        rs1DataD;
    logic [xlen-1:0]        rs2DataD;
    logic [xlen-1:0]        pcD;
    logic [xlen-1:0]        pcPlus4D;
    logic [xlen-1:0]        immD;
    logic [regAddrBits-1:0] rdD;
    logic [2:0]             funct3D;

    // Bundle in execute.
    logic                   validE;
    logic                   regWriteE;
    logic [1:0]             resultSrcE;
    logic                   jumpE;
    logic                   jumpRegE;
    logic                   branchE;
    logic [3:0]             aluControlE;
    logic                   aluSrcImmE;
    logic                   aluSrcPcE;
    logic [xlen-1:0]        rs1DataE;
    logic [xlen-1:0]        rs2DataE;
    logic [xlen-1:0]        pcE;
    logic [xlen-1:0]        pcPlus4E;
    logic [xlen-1:0]        immE;
    logic [regAddrBits-1:0] rdE;
    logic [2:0]             funct3E;

    fetchUnit fetch0 (.*);

    decodeStage decode0 (.*);

    idExReg idEx0 (
        .flush(redirect),
        .*
    );

    executeStage execute0 (.*);

endmodule

// ==== retireChecker.sv ====
`timescale 1ns/1ps

module retireChecker (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            wbCyc,
    input  logic [corePkg::xlen-1:0]        wbAdr,
    input  logic                            retireValid,
    input  logic [corePkg::xlen-1:0]        retirePc,
    input  logic [corePkg::regAddrBits-1:0] retireRd,
    input  logic [corePkg::xlen-1:0]        retireData,
    input  int                              rowCount,
    input  int                              waitLimit,
    input  logic [corePkg::xlen-1:0]        expPc,
    input  logic [corePkg::regAddrBits-1:0] expRd,
    input  logic [corePkg::xlen-1:0]        expData,
    output logic [4:0]                      rowIdx,
    output int                              errorCount,
    output int                              timeoutCount,
    output logic                            done
);
    import corePkg::*;

    int waited;

    task automatic compareField(input string field, input logic [xlen-1:0] expected,
                                input logic [xlen-1:0] observed);
        if (observed !== expected) begin
            $display("Fail at %0t: row %0d %s expected %h, observed %h", $time, rowIdx,
                     field, expected, observed);
            errorCount++;
        end
    endtask

    task automatic checkNoRetire();
        if (retireValid !== 1'b0) begin
            $display("Fail at %0t: retire seen before any instruction was fetched", $time);
            errorCount++;
        end
    endtask

    initial begin
        rowIdx = '0;
        errorCount = 0;
        timeoutCount = 0;
        done = 1'b0;
        waited = 0;
        @(posedge clk);
        while (!rstN && waited < waitLimit) begin
            @(posedge clk);
            waited++;
        end
        if (!rstN) begin
            $display("Timeout: reset was never released");
            timeoutCount++;
        end

        // Retire outputs settle after the rising edge and are sampled mid-cycle.
        waited = 0;
        @(negedge clk);
        while (!wbCyc && waited < waitLimit) begin
            checkNoRetire();
            @(negedge clk);
            waited++;
        end
        if (!wbCyc) begin
            $display("Timeout: no Wishbone request after reset");
            timeoutCount++;
        end else begin
            checkNoRetire();
            compareField("first wbAdr", resetPc, wbAdr);
        end

        // One retire per row in program order.
        for (int i = 0; i < rowCount && timeoutCount == 0; i++) begin
            rowIdx = 5'(i);
            waited = 0;
            @(negedge clk);
            while (!retireValid && waited < waitLimit) begin
                @(negedge clk);
                waited++;
            end
            if (!retireValid) begin
                $display("Timeout: no retire for row %0d", i);
                timeoutCount++;
            end else begin
                compareField("pc", expPc, retirePc);
                compareField("rd", xlen'(expRd), xlen'(retireRd));
                compareField("data", expData, retireData);
            end
        end
        done = 1'b1;
    end

endmodule

// ==== coreTb.sv ====
`timescale 1ns/1ps

module coreTb;
    import corePkg::*;

    localparam int progWords = 38;
    localparam int rowCount = 28;
    localparam int retireTimeout = 40;
    localparam int runTimeout = 2000;
    localparam logic [15:0] lfsrSeed = 16'd64554;

    // Instruction words indexed by wbAdr / 4.
    localparam logic [xlen-1:0] progMem [progWords] = '{
        32'h00500093, // 00 addi x1, x0, 5
        32'hFFD00113, // 04 addi x2, x0, -3
        32'h002081B3, // 08 add  x3, x1, x2
        32'h40118233, // 0C sub  x4, x3, x1
        32'h001272B3, // 10 and  x5, x4, x1
        32'h0022E333, // 14 or   x6, x5, x2
        32'h001343B3, // 18 xor  x7, x6, x1
        32'h00112433, // 1C slt  x8, x2, x1
        32'hFFF0A493, // 20 slti x9, x1, -1
        32'h0F03F513, // 24 andi x10, x7, 0xf0
        32'h7000E593, // 28 ori  x11, x1, 0x700
        32'hFFF0C613, // 2C xori x12, x1, -1
        32'h123456B7, // 30 lui  x13, 0x12345
        32'h00001717, // 34 auipc x14, 0x1
        32'h00708013, // 38 addi x0, x1, 7
        32'h001007B3, // 3C add  x15, x0, x1
        32'h00208463, // 40 beq  x1, x2, +8 (not taken)
        32'h00209663, // 44 bne  x1, x2, +12
        32'h00100813, // 48 skipped
        32'h00100813, // 4C skipped
        32'h00114663, // 50 blt  x2, x1, +12
        32'h00100813, // 54 skipped
        32'h00100813, // 58 skipped
        32'h0020D663, // 5C bge  x1, x2, +12
        32'h00100813, // 60 skipped
        32'h00100813, // 64 skipped
        32'h00115463, // 68 bge  x2, x1, +8 (not taken)
        32'h00C0096F, // 6C jal  x18, +12
        32'h00100813, // 70 skipped
        32'h00100813, // 74 skipped
        32'h09100993, // 78 addi x19, x0, 0x91
        32'h00098A67, // 7C jalr x20, 0(x19)
        32'h00100813, // 80 skipped
        32'h00100813, // 84 skipped
        32'h00100813, // 88 skipped
        32'h00100813, // 8C skipped
        32'h012A0AB3, // 90 add  x21, x20, x18
        32'h0000006F  // 94 jal  x0, 0
    };

    // Columns are pc, rd and writeback value in retire order.
    localparam logic [2*xlen+regAddrBits-1:0] expTable [rowCount] = '{
        {32'h00000000, 5'd1, 32'h00000005},
        {32'h00000004, 5'd2, 32'hFFFFFFFD},
        {32'h00000008, 5'd3, 32'h00000002},
        {32'h0000000C, 5'd4, 32'hFFFFFFFD},
        {32'h00000010, 5'd5, 32'h00000005},
        {32'h00000014, 5'd6, 32'hFFFFFFFD},
        {32'h00000018, 5'd7, 32'hFFFFFFF8},
        {32'h0000001C, 5'd8, 32'h00000001},
        {32'h00000020, 5'd9, 32'h00000000},
        {32'h00000024, 5'd10, 32'h000000F0},
        {32'h00000028, 5'd11, 32'h00000705},
        {32'h0000002C, 5'd12, 32'hFFFFFFFA},
        {32'h00000030, 5'd13, 32'h12345000},
        {32'h00000034, 5'd14, 32'h00001034},
        {32'h00000038, 5'd0, 32'h00000000},
        {32'h0000003C, 5'd15, 32'h00000005},
        {32'h00000040, 5'd0, 32'h00000000},
        {32'h00000044, 5'd0, 32'h00000000},
        {32'h00000050, 5'd0, 32'h00000000},
        {32'h0000005C, 5'd0, 32'h00000000},
        {32'h00000068, 5'd0, 32'h00000000},
        {32'h0000006C, 5'd18, 32'h00000070},
        {32'h00000078, 5'd19, 32'h00000091},
        {32'h0000007C, 5'd20, 32'h00000080},
        {32'h00000090, 5'd21, 32'h000000F0},
        {32'h00000094, 5'd0, 32'h00000000},
        {32'h00000094, 5'd0, 32'h00000000},
        {32'h00000094, 5'd0, 32'h00000000}
    };

    logic                   clk;
    logic                   rstN;
    logic                   wbCyc;
    logic                   wbStb;
    logic [xlen-1:0]        wbAdr;
    logic [xlen-1:0]        wbDatI = '0;
    logic                   wbAck = 1'b0;
    logic                   retireValid;
    logic [xlen-1:0]        retirePc;
    logic [regAddrBits-1:0] retireRd;
    logic [xlen-1:0]        retireData;
    logic [4:0]             rowIdx;
    logic [xlen-1:0]        expPc;
    logic [regAddrBits-1:0] expRd;
    logic [xlen-1:0]        expData;
    int                     errorCount;
    int                     timeoutCount;
    logic                   done;
    logic [15:0]            lfsr = lfsrSeed;
    int                     waitLeft = 0;
    int                     runCycles;

    // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic drawWait(output int cycles);
        cycles = 0;
        for (int b = 0; b < 2; b++) begin
            cycles = cycles * 2 + int'(lfsr[0]);
            lfsr = lfsrNext(lfsr);
        end
    endtask

    // Past the program, words end in 2'b00, which no supported opcode has.
    function automatic logic [xlen-1:0] fetchWord(input logic [xlen-1:0] adr);
        if (adr < xlen'(4 * progWords)) begin
            return progMem[adr[7:2]];
        end
        return {adr[31:2] ^ {adr[1:0], adr[31:4]}, 2'b00};
    endfunction

    assign expPc = expTable[rowIdx][68:37];
    assign expRd = expTable[rowIdx][36:32];
    assign expData = expTable[rowIdx][31:0];

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Wishbone slave with 0 to 3 wait states per beat.
    always @(negedge clk) begin
        if (!rstN) begin
            wbAck <= 1'b0;
        end else if (wbCyc && wbStb && waitLeft == 0) begin
            wbAck <= 1'b1;
            wbDatI <= fetchWord(wbAdr);
            drawWait(waitLeft);
        end else begin
            wbAck <= 1'b0;
            if (wbCyc && wbStb) begin
                waitLeft = waitLeft - 1;
            end
        end
    end

    coreTop dut0 (
        .clk(clk),
        .rstN(rstN),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbAdr(wbAdr),
        .wbDatI(wbDatI),
        .wbAck(wbAck),
        .retireValid(retireValid),
        .retirePc(retirePc),
        .retireRd(retireRd),
        .retireData(retireData)
    );

    retireChecker retireWatch0 (
        .clk(clk),
        .rstN(rstN),
        .wbCyc(wbCyc),
        .wbAdr(wbAdr),
        .retireValid(retireValid),
        .retirePc(retirePc),
        .retireRd(retireRd),
        .retireData(retireData),
        .rowCount(rowCount),
        .waitLimit(retireTimeout),
        .expPc(expPc),
        .expRd(expRd),
        .expData(expData),
        .rowIdx(rowIdx),
        .errorCount(errorCount),
        .timeoutCount(timeoutCount),
        .done(done)
    );

    initial begin
        rstN = 1'b0;
        repeat (5) @(negedge clk);
        rstN = 1'b1;
        runCycles = 0;
        while (!done && runCycles < runTimeout) begin
            @(negedge clk);
            runCycles++;
        end
        if (!done) begin
            $display("Timeout: the retire table was not finished");
        end
        $display("Errors: %0d, timeouts: %0d", errorCount, timeoutCount + int'(!done));
        if (errorCount == 0 && timeoutCount == 0 && done) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
corePkg.sv
fetchUnit.sv
regFile.sv
decodeStage.sv
idExReg.sv
executeStage.sv
coreTop.sv
retireChecker.sv
coreTb.sv

// ==== Makefile ====
SIM      ?= verilator
TOP      ?= coreTb
LOG      ?= sim.log
FILELIST ?= verilog.f
OBJDIR   ?= obj_dir

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) --binary --timing -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^RESULT: PASS$$' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
